/* source/cdb_defines.svh */
//////////////////////////////////////////////////
// Sizes of the write-back path; ROB depth must be a power of two
//////////////////////////////////////////////////
`ifndef CDB_DEFINES_SVH
`define CDB_DEFINES_SVH

// Execution units, unit 0 is the maximum-priority one
`define CDB_EU_N 4

// Result width carried on the CDB
`define CDB_DATA_W 32

// ROB entries, index wraps naturally
`define CDB_ROB_DEPTH 8

// CDB queue entries between arbiter and ROB
`define CDB_FIFO_DEPTH 4

`endif

/* source/cdb_pkg.sv */
//////////////////////////////////////////////////
// Types shared by the write-back path
//////////////////////////////////////////////////
`include "cdb_defines.svh"

package cdb_pkg;

    // ROB entry index, log2 of the ROB depth
    typedef logic [$clog2(`CDB_ROB_DEPTH)-1:0] rob_idx_t;

    // Execution unit number as seen by the arbiter
    typedef logic [$clog2(`CDB_EU_N)-1:0] eu_sel_t;

    // One finished result on the CDB
    // Field order gives rob_idx in the top bits
    typedef struct packed {
        rob_idx_t               rob_idx;
        logic [`CDB_DATA_W-1:0] value;
        logic                   except;
    } cdb_entry_t;

endpackage

/* source/cdb_if.sv */
//////////////////////////////////////////////////
// Valid/ready link; entry must hold steady while valid waits
//////////////////////////////////////////////////
interface cdb_if #(
    parameter type payload_t = cdb_pkg::cdb_entry_t
);

    // Producer has an entry on the link
    logic     valid;
    // Consumer takes it on this edge
    logic     ready;
    // Payload, stable until the transfer
    payload_t entry;

    // Producer side
    modport source (
        output valid,
        output entry,
        input  ready
    );

    // Consumer side
    modport sink (
        input  valid,
        input  entry,
        output ready
    );

endinterface

/* source/eu_result_slot.sv */
//////////////////////////////////////////////////
// One-entry holding register; a flush drops its result
//////////////////////////////////////////////////
module eu_result_slot (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                eu_valid_i,
    output logic                eu_ready_o,
    input  cdb_pkg::cdb_entry_t eu_entry_i,
    cdb_if.source               slot
);

    import cdb_pkg::*;

    logic       full_q;
    cdb_entry_t data_q;
    logic       load;
    logic       drain;

    // Arbiter takes the held result this cycle
    assign drain = full_q & slot.ready;

    // Accept when empty or when the old result leaves now
    assign eu_ready_o = ~full_q | slot.ready;
    assign load       = eu_valid_i & eu_ready_o;

    // Valid and payload go straight to the arbiter
    assign slot.valid = full_q;
    assign slot.entry = data_q;

    // Occupancy flag
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            full_q <= 1'b0;
        end else if (flush_i) begin
            full_q <= 1'b0;
        end else if (load) begin
            // Refill wins over drain in the same cycle
            full_q <= 1'b1;
        end else if (drain) begin
            full_q <= 1'b0;
        end
    end

    // Payload register
    always_ff @(posedge clk_i) begin
        if (load) begin
            data_q <= eu_entry_i;
        end
    end

endmodule

/* source/cdb_arbiter.sv */
//////////////////////////////////////////////////
// Unit 0 always wins; others are served from a snapshot
// A request leaves the snapshot only on a real transfer
//////////////////////////////////////////////////
`include "cdb_defines.svh"

module cdb_arbiter (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  flush_i,
    cdb_if.sink   slot [`CDB_EU_N],
    cdb_if.source cdb
);

    import cdb_pkg::*;

    localparam int unsigned EU_N = `CDB_EU_N;

    // Flattened slot signals
    logic [EU_N-1:0] req_a;
    logic [EU_N-1:0] ready_a;
    cdb_entry_t      entry_a [EU_N];

    // Remaining snapshot of units 1 to N-1
    logic [EU_N-1:1] rem_q;
    logic [EU_N-1:1] rem_d;
    logic [EU_N-1:1] cand;

    // Winner
    eu_sel_t         win_sel;
    logic [EU_N-1:0] win_oh;
    logic            xfer;

    // Interface arrays need constant indices
    for (genvar g = 0; g < EU_N; g++) begin : g_slot
        assign req_a[g]      = slot[g].valid;
        assign entry_a[g]    = slot[g].entry;
        assign slot[g].ready = ready_a[g];
    end

    // Reload from live requests only when the snapshot is empty
    assign cand = (|rem_q) ? rem_q : req_a[EU_N-1:1];

    // Unit 0 first, then lowest index in the candidate set
    always_comb begin
        win_sel = '0;
        if (!req_a[0]) begin
            // Descending scan, so the lowest set bit is kept
            for (int i = EU_N - 1; i >= 1; i--) begin
                if (cand[i]) begin
                    win_sel = eu_sel_t'(i);
                end
            end
        end
    end

    // One-hot grant, empty when nobody requests
    always_comb begin
        win_oh = '0;
        if (cdb.valid) begin
            win_oh[win_sel] = 1'b1;
        end
    end

    // CDB side
    assign cdb.valid = req_a[0] | (|cand);
    assign cdb.entry = entry_a[win_sel];
    assign xfer      = cdb.valid & cdb.ready;

    // Only the winner sees the queue's ready
    assign ready_a = win_oh & {EU_N{cdb.ready}};

    // Served bit drops only when its transfer happens
    always_comb begin
        rem_d = cand;
        if (xfer && !req_a[0]) begin
            rem_d[win_sel] = 1'b0;
        end
    end

    // Snapshot register
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rem_q <= '0;
        end else if (flush_i) begin
            rem_q <= '0;
        end else begin
            rem_q <= rem_d;
        end
    end

endmodule

/* source/cdb_fifo.sv */
//////////////////////////////////////////////////
// Circular queue; payload must match the link's entry type
//////////////////////////////////////////////////
`include "cdb_defines.svh"

module cdb_fifo #(
    parameter type payload_t = cdb_pkg::cdb_entry_t
) (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  flush_i,
    cdb_if.sink   in,
    cdb_if.source out
);

    localparam int unsigned DEPTH = `CDB_FIFO_DEPTH;
    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push;
    logic             pop;

    // Ready while there is room, valid while not empty
    assign in.ready  = (count_q != CNT_W'(DEPTH));
    assign out.valid = (count_q != '0);
    assign out.entry = mem[rd_ptr_q];

    assign push = in.valid & in.ready;
    assign pop  = out.valid & out.ready;

    // Pointers and occupancy
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                // Wrap explicitly, depth need not be a power of two
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Storage, written at the write pointer
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr_q] <= in.entry;
        end
    end

endmodule

/* source/rob_writeback.sv */
//////////////////////////////////////////////////
// ROB table; each allocated index is written back exactly once
//////////////////////////////////////////////////
`include "cdb_defines.svh"

module rob_writeback (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   flush_i,
    input  logic                   alloc_valid_i,
    output logic                   alloc_ready_o,
    output cdb_pkg::rob_idx_t      alloc_idx_o,
    cdb_if.sink                    wb,
    output logic                   commit_valid_o,
    input  logic                   commit_ready_i,
    output cdb_pkg::rob_idx_t      commit_rob_idx_o,
    output logic [`CDB_DATA_W-1:0] commit_value_o,
    output logic                   commit_except_o
);

    import cdb_pkg::*;

    localparam int unsigned DEPTH = `CDB_ROB_DEPTH;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    // Control state
    rob_idx_t         head_q;
    rob_idx_t         tail_q;
    logic [CNT_W-1:0] count_q;
    logic [DEPTH-1:0] done_q;

    // Result storage
    logic [`CDB_DATA_W-1:0] value_q  [DEPTH];
    logic                   except_q [DEPTH];

    logic alloc_fire;
    logic wb_fire;
    logic commit_fire;

    // Allocation at the tail while not full
    assign alloc_ready_o = (count_q != CNT_W'(DEPTH));
    assign alloc_idx_o   = tail_q;
    assign alloc_fire    = alloc_valid_i & alloc_ready_o;

    // Write port never stalls
    assign wb.ready = 1'b1;
    assign wb_fire  = wb.valid;

    // Head commits once its result is back
    assign commit_valid_o   = (count_q != '0) & done_q[head_q];
    assign commit_rob_idx_o = head_q;
    assign commit_value_o   = value_q[head_q];
    assign commit_except_o  = except_q[head_q];
    assign commit_fire      = commit_valid_o & commit_ready_i;

    // Pointers, occupancy and done bits
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            done_q  <= '0;
        end else if (flush_i) begin
            // Whole window dropped, restart from index 0
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            done_q  <= '0;
        end else begin
            if (alloc_fire) begin
                tail_q <= tail_q + 1'b1;
            end
            if (commit_fire) begin
                head_q         <= head_q + 1'b1;
                done_q[head_q] <= 1'b0;
            end
            // Written index is live, so never the head being freed
            if (wb_fire) begin
                done_q[wb.entry.rob_idx] <= 1'b1;
            end
            case ({alloc_fire, commit_fire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Result fields land at the entry's own index
    always_ff @(posedge clk_i) begin
        if (wb_fire) begin
            value_q[wb.entry.rob_idx]  <= wb.entry.value;
            except_q[wb.entry.rob_idx] <= wb.entry.except;
        end
    end

endmodule

/* source/cdb_top.sv */
//////////////////////////////////////////////////
// Write-back path top; per-unit ports are packed, unit 0 first
//////////////////////////////////////////////////
`include "cdb_defines.svh"

module cdb_top (
    input  logic                                    clk_i,
    input  logic                                    rst_n_i,
    input  logic                                    flush_i,
    // Execution unit results
    input  logic [`CDB_EU_N-1:0]                    eu_valid_i,
    output logic [`CDB_EU_N-1:0]                    eu_ready_o,
    input  cdb_pkg::rob_idx_t [`CDB_EU_N-1:0]       eu_rob_idx_i,
    input  logic [`CDB_EU_N-1:0][`CDB_DATA_W-1:0]   eu_value_i,
    input  logic [`CDB_EU_N-1:0]                    eu_except_i,
    // ROB index allocation
    input  logic                                    alloc_valid_i,
    output logic                                    alloc_ready_o,
    output cdb_pkg::rob_idx_t                       alloc_idx_o,
    // CDB broadcast, one pulse per transfer
    output logic                                    cdb_valid_o,
    output cdb_pkg::rob_idx_t                       cdb_rob_idx_o,
    output logic [`CDB_DATA_W-1:0]                  cdb_value_o,
    // In-order commit
    output logic                                    commit_valid_o,
    input  logic                                    commit_ready_i,
    output cdb_pkg::rob_idx_t                       commit_rob_idx_o,
    output logic [`CDB_DATA_W-1:0]                  commit_value_o,
    output logic                                    commit_except_o
);

    import cdb_pkg::*;

    cdb_entry_t eu_entry [`CDB_EU_N];

    // Slot to arbiter, arbiter to queue, queue to ROB
    cdb_if slot_if [`CDB_EU_N] ();
    cdb_if cdb_bus ();
    cdb_if wb_if ();

    // One holding slot per execution unit
    for (genvar g = 0; g < `CDB_EU_N; g++) begin : g_eu
        assign eu_entry[g] = '{
            rob_idx: eu_rob_idx_i[g],
            value:   eu_value_i[g],
            except:  eu_except_i[g]
        };

        eu_result_slot u_slot (
            .clk_i      (clk_i),
            .rst_n_i    (rst_n_i),
            .flush_i    (flush_i),
            .eu_valid_i (eu_valid_i[g]),
            .eu_ready_o (eu_ready_o[g]),
            .eu_entry_i (eu_entry[g]),
            .slot       (slot_if[g])
        );
    end

    cdb_arbiter u_arbiter (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .slot    (slot_if),
        .cdb     (cdb_bus)
    );

    cdb_fifo u_fifo (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .in      (cdb_bus),
        .out     (wb_if)
    );

    rob_writeback u_rob (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .alloc_valid_i    (alloc_valid_i),
        .alloc_ready_o    (alloc_ready_o),
        .alloc_idx_o      (alloc_idx_o),
        .wb               (wb_if),
        .commit_valid_o   (commit_valid_o),
        .commit_ready_i   (commit_ready_i),
        .commit_rob_idx_o (commit_rob_idx_o),
        .commit_value_o   (commit_value_o),
        .commit_except_o  (commit_except_o)
    );

    // Broadcast copy, high only when the queue takes the entry
    assign cdb_valid_o   = cdb_bus.valid & cdb_bus.ready;
    assign cdb_rob_idx_o = cdb_bus.entry.rob_idx;
    assign cdb_value_o   = cdb_bus.entry.value;

endmodule

/* bench/cdb_props.sv */
//////////////////////////////////////////////////
// Arbiter checks; fairness bound assumes unit 0 is not back to back
//////////////////////////////////////////////////
`include "cdb_defines.svh"

module cdb_props (
    input logic                   clk_i,
    input logic                   rst_n_i,
    input logic                   flush_i,
    input logic [`CDB_EU_N-1:0]   req_i,
    input logic [`CDB_EU_N-1:0]   grant_i,
    input cdb_pkg::eu_sel_t       win_sel_i,
    input logic                   xfer_i
);

    import cdb_pkg::*;

    localparam int EU_N = `CDB_EU_N;

    // Transfers of other units 1 to N-1 while a unit waits
    logic [3:0] wait_cnt [1:EU_N-1];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int u = 1; u < EU_N; u++) begin
                wait_cnt[u] <= '0;
            end
        end else begin
            for (int u = 1; u < EU_N; u++) begin
                if (flush_i || !req_i[u] || grant_i[u]) begin
                    wait_cnt[u] <= '0;
                end else if (xfer_i && !grant_i[0]) begin
                    wait_cnt[u] <= wait_cnt[u] + 1'b1;
                end
            end
        end
    end

    // Single grant
    a_one_grant: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(grant_i))
        else $error("more than one slot sees ready");

    // Unit 0 wins whenever it requests
    a_unit0_first: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        req_i[0] |-> !xfer_i || grant_i[0])
        else $error("unit 0 valid but not served");

    // Transfer comes from the valid slot that won
    a_xfer_has_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        xfer_i |-> req_i[win_sel_i] && grant_i[win_sel_i])
        else $error("cdb transfer without a valid slot");

    // Bounded wait for units 1 to N-1
    for (genvar g = 1; g < EU_N; g++) begin : g_fair
        a_bounded_wait: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            wait_cnt[g] <= 4'(EU_N))
            else $error("slot waited more than the unit count of transfers");
    end

endmodule

bind cdb_arbiter cdb_props u_props (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .flush_i   (flush_i),
    .req_i     (req_a),
    .grant_i   (ready_a),
    .win_sel_i (win_sel),
    .xfer_i    (xfer)
);

/* bench/cdb_tb.sv */
//////////////////////////////////////////////////
// Vector-driven bench; groups hold at most six results
//////////////////////////////////////////////////
`include "cdb_defines.svh"

module cdb_tb;

    import cdb_pkg::*;

    localparam int EU_N       = `CDB_EU_N;
    localparam int DATA_W     = `CDB_DATA_W;
    localparam int MAX_VEC    = 64;
    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DLY  = 10;

    logic                             clk_i;
    logic                             rst_n_i;
    logic                             flush_i;
    logic [EU_N-1:0]                  eu_valid_i;
    logic [EU_N-1:0]                  eu_ready_o;
    rob_idx_t [EU_N-1:0]              eu_rob_idx_i;
    logic [EU_N-1:0][DATA_W-1:0]      eu_value_i;
    logic [EU_N-1:0]                  eu_except_i;
    logic                             alloc_valid_i;
    logic                             alloc_ready_o;
    rob_idx_t                         alloc_idx_o;
    logic                             cdb_valid_o;
    rob_idx_t                         cdb_rob_idx_o;
    logic [DATA_W-1:0]                cdb_value_o;
    logic                             commit_valid_o;
    logic                             commit_ready_i;
    rob_idx_t                         commit_rob_idx_o;
    logic [DATA_W-1:0]                commit_value_o;
    logic                             commit_except_o;

    // Vector word: op, unit, value, except, group
    logic [51:0]       vec_mem [MAX_VEC];
    int                n_vec;
    rob_idx_t          op_idx [MAX_VEC];
    bit                posted [MAX_VEC];
    bit                served [MAX_VEC];
    cdb_entry_t        exp_q [$];
    cdb_entry_t        exp_cdb_q [$];
    rob_idx_t          next_idx;
    bit                stall_on;
    bit                saw_full;
    int unsigned       seed_val;

    cdb_top DUT (.*);

    function automatic logic [3:0] vec_op(int k);
        return vec_mem[k][51:48];
    endfunction

    function automatic logic [3:0] vec_unit(int k);
        return vec_mem[k][47:44];
    endfunction

    function automatic cdb_entry_t vec_entry(int k);
        cdb_entry_t e;
        e.rob_idx = op_idx[k];
        e.value   = vec_mem[k][43:12];
        e.except  = vec_mem[k][8];
        return e;
    endfunction

    task automatic report_failure(string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(string name, logic [63:0] got, logic [63:0] expected);
        if (got !== expected) begin
            $display("Error: %s got 0x%0h expected 0x%0h", name, got, expected);
            $display("Errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    // Move to the drive point of the next cycle
    task automatic step();
        @(posedge clk_i);
        #(DRIVE_DLY);
    endtask

    // Takes one ROB index, expected index follows allocation order
    task automatic alloc_one(int k);
        alloc_valid_i = 1'b1;
        while (!alloc_ready_o) begin
            if (stall_on) begin
                saw_full = 1'b1;
                stall_on = 1'b0;
            end
            step();
        end
        check_value("alloc_idx_o", 64'(alloc_idx_o), 64'(next_idx));
        op_idx[k] = alloc_idx_o;
        exp_q.push_back(vec_entry(k));
        next_idx = next_idx + 1'b1;
        step();
        alloc_valid_i = 1'b0;
    endtask

    // Oldest result of a unit in the group that has not reached the CDB yet
    function automatic int oldest_unserved(int u, int first, int last);
        int sel;
        sel = -1;
        for (int k = last - 1; k >= first; k--) begin
            if (!served[k] && vec_unit(k) == 4'(u)) begin
                sel = k;
            end
        end
        return sel;
    endfunction

    // CDB order of a group posted from idle
    // Unit 0 first, others lowest first out of a snapshot
    task automatic predict_cdb_order(int first, int last);
        logic [EU_N-1:0] pend;
        logic [EU_N-1:1] snap;
        int              win;
        int              k;
        snap = '0;
        for (int n = first; n < last; n++) begin
            served[n] = 1'b0;
        end
        for (int n = first; n < last; n++) begin
            for (int u = 0; u < EU_N; u++) begin
                pend[u] = (oldest_unserved(u, first, last) >= 0);
            end
            // New snapshot only once the previous one is used up
            if (snap == '0) begin
                snap = pend[EU_N-1:1];
            end
            win = -1;
            if (pend[0]) begin
                win = 0;
            end else begin
                for (int u = 1; u < EU_N; u++) begin
                    if (win < 0 && snap[u]) begin
                        win = u;
                    end
                end
                snap[win] = 1'b0;
            end
            k = oldest_unserved(win, first, last);
            served[k] = 1'b1;
            exp_cdb_q.push_back(vec_entry(k));
        end
    endtask

    // Offers each unit its oldest unposted result until all are taken
    task automatic post_group(int first, int last);
        int left;
        int sel;
        int pick [EU_N];
        left = last - first;
        for (int k = first; k < last; k++) begin
            posted[k] = 1'b0;
        end
        while (left > 0) begin
            eu_valid_i = '0;
            for (int u = 0; u < EU_N; u++) begin
                sel = -1;
                for (int k = last - 1; k >= first; k--) begin
                    if (!posted[k] && vec_unit(k) == 4'(u)) begin
                        sel = k;
                    end
                end
                pick[u] = sel;
                if (sel >= 0) begin
                    eu_valid_i[u]   = 1'b1;
                    eu_rob_idx_i[u] = op_idx[sel];
                    eu_value_i[u]   = vec_mem[sel][43:12];
                    eu_except_i[u]  = vec_mem[sel][8];
                end
            end
            for (int u = 0; u < EU_N; u++) begin
                if (pick[u] >= 0 && eu_ready_o[u]) begin
                    posted[pick[u]] = 1'b1;
                    left--;
                end
            end
            step();
        end
        eu_valid_i = '0;
    endtask

    task automatic wait_idle();
        while (exp_q.size() != 0) begin
            step();
        end
    endtask

    task automatic run_group(int first, int last);
        logic [3:0] kind;
        kind = vec_op(first);
        if (kind == 4'h1) begin
            wait_idle();
        end
        if (kind == 4'h2 || kind == 4'h3) begin
            stall_on = 1'b1;
        end
        for (int k = first; k < last; k++) begin
            alloc_one(k);
        end
        if (kind == 4'h1) begin
            predict_cdb_order(first, last);
        end
        post_group(first, last);
        if (kind == 4'h3) begin
            // Everything in flight is dropped, index restarts at 0
            flush_i = 1'b1;
            step();
            flush_i = 1'b0;
            exp_q.delete();
            next_idx = '0;
            stall_on = 1'b0;
            check_value("alloc_idx_o", 64'(alloc_idx_o), 64'h0);
        end
        if (kind == 4'h1) begin
            wait_idle();
            check_value("cdb_pending", 64'(exp_cdb_q.size()), 64'h0);
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // Random commit stalls, forced low during stall phases
    initial begin
        commit_ready_i = 1'b0;
        seed_val       = $urandom(32'h9cf);
        forever begin
            step();
            commit_ready_i = stall_on ? 1'b0 : (($urandom % 4) != 0);
        end
    end

    // Commit and CDB monitors, sampled mid-cycle
    initial begin
        cdb_entry_t e;
        cdb_entry_t c;
        forever begin
            @(negedge clk_i);
            if (rst_n_i && commit_valid_o && commit_ready_i) begin
                if (exp_q.size() == 0) begin
                    report_failure("A commit appeared with no operation outstanding");
                end else begin
                    e = exp_q.pop_front();
                    check_value("commit_rob_idx_o", 64'(commit_rob_idx_o), 64'(e.rob_idx));
                    check_value("commit_value_o", 64'(commit_value_o), 64'(e.value));
                    check_value("commit_except_o", 64'(commit_except_o), 64'(e.except));
                end
            end
            if (rst_n_i && cdb_valid_o && exp_cdb_q.size() != 0) begin
                c = exp_cdb_q.pop_front();
                check_value("cdb_rob_idx_o", 64'(cdb_rob_idx_o), 64'(c.rob_idx));
                check_value("cdb_value_o", 64'(cdb_value_o), 64'(c.value));
            end
        end
    end

    // Watchdog sized from the vector count
    initial begin
        #1;
        repeat ((n_vec + 10) * 20) @(posedge clk_i);
        report_failure("Timeout: the run did not finish in time");
    end

    initial begin
        int i;
        int j;
        rst_n_i       = 1'b0;
        flush_i       = 1'b0;
        eu_valid_i    = '0;
        eu_rob_idx_i  = '0;
        eu_value_i    = '0;
        eu_except_i   = '0;
        alloc_valid_i = 1'b0;
        next_idx      = '0;
        stall_on      = 1'b0;
        saw_full      = 1'b0;
        $readmemh("bench/cdb_vectors.txt", vec_mem);
        n_vec = 0;
        while (n_vec < MAX_VEC && vec_mem[n_vec][51:48] !== 4'hf) begin
            if ($isunknown(vec_mem[n_vec])) begin
                report_failure("The vector file is missing or malformed");
            end
            n_vec++;
        end
        repeat (8) @(posedge clk_i);
        #(DRIVE_DLY);
        rst_n_i = 1'b1;
        step();
        i = 0;
        while (i < n_vec) begin
            j = i;
            while (j < n_vec && vec_mem[j][7:0] == vec_mem[i][7:0]) begin
                j++;
            end
            run_group(i, j);
            i = j;
        end
        wait_idle();
        check_value("alloc_full_seen", 64'(saw_full), 64'h1);
        $display("No errors");
        $finish;
    end

endmodule

/* build.f */
+incdir+source
source/cdb_pkg.sv
source/cdb_if.sv
source/eu_result_slot.sv
source/cdb_arbiter.sv
source/cdb_fifo.sv
source/rob_writeback.sv
source/cdb_top.sv
bench/cdb_props.sv
bench/cdb_tb.sv

/* run.sh */
#!/bin/sh
# Builds the write-back path testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module cdb_tb \
    -f build.f \
    -o cdb_sim

./obj_dir/cdb_sim

/* bench/cdb_vectors.txt */
// Columns: op unit value except group, one 52-bit hex word per line
// op 0 plain, 1 CDB order checked, 2 commit stalled, 3 flush after posting, f ends
0_2_00000101_0_01
0_3_00000102_0_01
0_1_00000103_1_01
0_0_00000104_0_01
1_0_00000201_0_02
1_1_00000202_0_02
1_2_00000203_1_02
1_3_00000204_0_02
1_1_00000301_0_03
1_2_00000302_0_03
1_3_00000303_0_03
1_1_00000304_1_03
2_1_00000401_0_04
2_2_00000402_0_04
2_3_00000403_1_04
2_0_00000404_0_04
2_1_00000405_0_04
2_2_00000406_0_04
2_3_00000501_0_05
2_1_00000502_0_05
2_2_00000503_1_05
2_0_00000504_0_05
0_2_00000601_0_06
0_1_00000602_0_06
0_3_00000603_1_06
0_0_00000604_0_06
0_2_00000605_0_06
3_1_00000701_0_07
3_0_00000702_1_07
3_3_00000703_0_07
0_3_00000801_0_08
0_0_00000802_0_08
0_2_00000803_1_08
0_1_00000804_0_08
1_2_00000901_0_09
1_1_00000902_0_09
f_0_00000000_0_ff
